//--- flist.f
+incdir+dv
src/memGamePkg.sv
src/lfsrSource.sv
src/dealShuffler.sv
src/boardTable.sv
src/cardPlacer.sv
src/gameControl.sv
src/memGameTop.sv
dv/memGameTb.sv

//--- Makefile
# Verilator flow for the memory game testbench

VERILATOR ?= verilator
TOP       ?= memGameTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/memGameModel.svh
`ifndef MEM_GAME_MODEL_SVH
`define MEM_GAME_MODEL_SVH

// Reference board state, mirrors the flip rule of the game
logic [3:0] mCard    [16];
logic       mFaceUp  [16];
logic       mMatched [16];
logic [3:0] mPairs;
logic [7:0] mAttempts;
logic       mDealt;
logic       mFirstOpen;
int         mFirstSlot;
logic       mMisShow;
int         mMisA;
int         mMisB;

// Board, score and flip state back to zero, cards kept
task automatic modelClear();
    for (int s = 0; s < 16; s++)
    begin
        mFaceUp[s]  = 1'b0;
        mMatched[s] = 1'b0;
    end
    mPairs     = '0;
    mAttempts  = '0;
    mFirstOpen = 1'b0;
    mMisShow   = 1'b0;
endtask

task automatic modelFlip(input int slot);
    if (!mDealt || mFaceUp[slot] || mMatched[slot])
        return;
    // Old mismatch goes face down first
    if (mMisShow)
    begin
        mFaceUp[mMisA] = 1'b0;
        mFaceUp[mMisB] = 1'b0;
        mMisShow       = 1'b0;
    end
    mFaceUp[slot] = 1'b1;
    if (!mFirstOpen)
    begin
        mFirstOpen = 1'b1;
        mFirstSlot = slot;
    end
    else
    begin
        mFirstOpen = 1'b0;
        if (mAttempts != 8'hFF)
            mAttempts = mAttempts + 8'd1;
        // Cards 2k and 2k+1 form pair k
        if ((mCard[slot] >> 1) == (mCard[mFirstSlot] >> 1))
        begin
            mMatched[slot]       = 1'b1;
            mMatched[mFirstSlot] = 1'b1;
            mPairs               = mPairs + 4'd1;
        end
        else
        begin
            mMisShow = 1'b1;
            mMisA    = mFirstSlot;
            mMisB    = slot;
        end
    end
endtask

`endif

//--- dv/memGameTb.sv
`default_nettype none

module memGameTb
    import memGamePkg::*;
;

    localparam logic [15:0] SEED_LFSR = 16'hACE1;
    localparam logic [9:0]  ORIGIN_X  = 10'd64;
    localparam logic [9:0]  ORIGIN_Y  = 10'd48;
    localparam logic [9:0]  PITCH_X   = 10'd128;
    localparam logic [9:0]  PITCH_Y   = 10'd104;
    localparam int          ACK_LIMIT = 20;
    localparam int          POLL_LIMIT = 400;

    logic        FPGA_Clk;
    logic        rstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [5:0]  wbAdr;
    logic [31:0] wbDatW;
    wire  [31:0] wbDatR;
    wire         wbAck;

    int mismatchCount;
    int otherCount;

    `include "memGameModel.svh"

    memGameTop #(
        .LFSR_SEED(SEED_LFSR), .ORIGIN_X(ORIGIN_X), .ORIGIN_Y(ORIGIN_Y),
        .PITCH_X(PITCH_X), .PITCH_Y(PITCH_Y)
    ) u_memGameTop (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck));

    initial
    begin
        FPGA_Clk = 1'b0;
        forever #2 FPGA_Clk = ~FPGA_Clk;
    end

    task automatic finishRun();
        $display("errors: mismatches=%0d other=%0d", mismatchCount, otherCount);
        if ((mismatchCount == 0) && (otherCount == 0))
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    //////////////////////
    // Bus tasks
    //////////////////////
    task automatic busAccess(input logic we, input logic [5:0] adr, input logic [31:0] datW,
                             output logic [31:0] datR);
        int n;
        @(negedge FPGA_Clk);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = datW;
        n      = 0;
        datR   = '0;
        do
        begin
            @(negedge FPGA_Clk);
            n++;
        end
        while (!wbAck && (n < ACK_LIMIT));
        if (!wbAck)
        begin
            otherCount++;
            $display("no bus ack for address %0d within %0d cycles", adr, ACK_LIMIT);
            finishRun();
        end
        else
        begin
            datR = wbDatR;
            // Strobe stays up through the edge that takes the ack
            @(negedge FPGA_Clk);
            wbCyc = 1'b0;
            wbStb = 1'b0;
            wbWe  = 1'b0;
        end
    endtask

    task automatic wbWrite(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        busAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [5:0] adr, output logic [31:0] dat);
        busAccess(1'b0, adr, 32'd0, dat);
    endtask

    //////////////////////
    // Board checks
    //////////////////////
    task automatic checkBoard(input string tag);
        logic [31:0] d;
        for (int s = 0; s < 16; s++)
        begin
            wbRead(ADR_SLOT_BASE + 6'(s), d);
            checkEq(d, {26'd0, mMatched[s], mFaceUp[s], mCard[s]},
                    $sformatf("%s slot %0d", tag, s));
        end
        wbRead(ADR_SCORE, d);
        checkEq(d, {16'd0, mAttempts, 4'd0, mPairs}, {tag, " score"});
    endtask

    task automatic flipAndCheck(input int slot, input string tag);
        wbWrite(ADR_FLIP, 32'(slot));
        modelFlip(slot);
        checkBoard(tag);
    endtask

    task automatic dealAndCheck();
        logic [31:0] d;
        logic [15:0] seen;
        int          n;
        wbWrite(ADR_CTRL, 32'd1);
        modelClear();
        n = 0;
        d = '0;
        while (!d[1] && (n < POLL_LIMIT))
        begin
            wbRead(ADR_CTRL, d);
            // Busy until the last card lands, then done, never won
            checkEq(32'(d[2:0]), d[1] ? 32'd2 : 32'd1, "ctrl while dealing");
            n++;
        end
        if (!d[1])
        begin
            otherCount++;
            $display("deal did not finish within %0d polls", POLL_LIMIT);
            finishRun();
        end
        else
        begin
            mDealt = 1'b1;
            seen   = '0;
            for (int s = 0; s < 16; s++)
            begin
                wbRead(ADR_SLOT_BASE + 6'(s), d);
                checkEq({26'd0, d[5:4], 4'd0}, 32'd0,
                        $sformatf("flags after deal slot %0d", s));
                checkEq(32'(seen[d[3:0]]), 32'd0, $sformatf("duplicate card in slot %0d", s));
                seen[d[3:0]] = 1'b1;
                mCard[s]     = d[3:0];
            end
            checkEq(32'(seen), 32'h0000FFFF, "deal permutation");
            checkBoard("after deal");
        end
    endtask

    // Next slot for the solver, partner of an open card when there is one
    function automatic int pickSolveSlot();
        if (mFirstOpen)
        begin
            for (int s = 0; s < 16; s++)
                if ((s != mFirstSlot) && ((mCard[s] >> 1) == (mCard[mFirstSlot] >> 1)))
                    return s;
        end
        for (int s = 0; s < 16; s++)
            if (!mMatched[s] && !mFaceUp[s])
                return s;
        return 0;
    endfunction

    initial
    begin
        logic [31:0] d;
        int          slot;
        int          prevSlot;
        int          guard;
        wbCyc         = 1'b0;
        wbStb         = 1'b0;
        wbWe          = 1'b0;
        wbAdr         = '0;
        wbDatW        = '0;
        rstN          = 1'b0;
        mismatchCount = 0;
        otherCount    = 0;
        void'($urandom(57));
        for (int s = 0; s < 16; s++)
            mCard[s] = '0;
        mDealt = 1'b0;
        modelClear();
        repeat (3) @(negedge FPGA_Clk);
        rstN = 1'b1;

        // Idle board after reset
        wbRead(ADR_CTRL, d);
        checkEq(d, 32'd0, "ctrl after reset");
        flipAndCheck(5, "flip before deal");

        dealAndCheck();
        for (int s = 0; s < 16; s++)
        begin
            wbRead(ADR_POS_BASE + 6'(s), d);
            checkEq(d, {6'd0, 10'(ORIGIN_Y + 10'(s / 4) * PITCH_Y),
                        6'd0, 10'(ORIGIN_X + 10'(s % 4) * PITCH_X)},
                    $sformatf("position slot %0d", s));
        end

        // Random flips, repeats included
        prevSlot = 0;
        for (int i = 0; i < 40; i++)
        begin
            slot = ($urandom % 4 == 0) ? prevSlot : int'($urandom % 16);
            flipAndCheck(slot, $sformatf("random flip %0d", i));
            prevSlot = slot;
        end

        // Solve with the model's knowledge of the cards
        guard = 0;
        while ((mPairs != 4'd8) && (guard < 64))
        begin
            flipAndCheck(pickSolveSlot(), "solve");
            guard++;
        end
        if (mPairs != 4'd8)
        begin
            otherCount++;
            $display("solver did not finish the game");
        end
        wbRead(ADR_CTRL, d);
        checkEq(d, 32'd6, "ctrl after win");

        // Second game
        dealAndCheck();
        wbRead(ADR_CTRL, d);
        checkEq(d, 32'd2, "ctrl after second deal");
        finishRun();
    end

endmodule

`default_nettype wire

//--- src/memGameTop.sv
`default_nettype none

module memGameTop
    import memGamePkg::*;
#(
    parameter logic [15:0] LFSR_SEED = 16'hACE1,
    parameter logic [9:0]  ORIGIN_X  = 10'd64,
    parameter logic [9:0]  ORIGIN_Y  = 10'd48,
    parameter logic [9:0]  PITCH_X   = 10'd128,
    parameter logic [9:0]  PITCH_Y   = 10'd104
)
(
    input  wire         FPGA_Clk,
    input  wire         rstN,
    input  wire         wbCyc,
    input  wire         wbStb,
    input  wire         wbWe,
    input  wire  [5:0]  wbAdr,
    input  wire  [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck
);

    logic [SLOT_W-1:0] rndBits, dealWrSlot, dealWrCard, flagWrSlot, rdCard;
    logic              dealStart, dealWrEn, dealBusy, dealDone;
    logic              flagWrEn, flagFaceUp, flagMatched, clearFlags, rdFaceUp, rdMatched;
    logic [9:0]        posX, posY;
    boardPos_u         rdPos;

    lfsrSource #(.LFSR_SEED(LFSR_SEED)) u_lfsrSource (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN), .rndBits(rndBits));

    dealShuffler u_dealShuffler (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN), .dealStart(dealStart), .rndBits(rndBits),
        .dealWrEn(dealWrEn), .dealWrSlot(dealWrSlot), .dealWrCard(dealWrCard),
        .dealBusy(dealBusy), .dealDone(dealDone));

    boardTable u_boardTable (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN),
        .dealWrEn(dealWrEn), .dealWrSlot(dealWrSlot), .dealWrCard(dealWrCard),
        .flagWrEn(flagWrEn), .flagWrSlot(flagWrSlot), .flagFaceUp(flagFaceUp),
        .flagMatched(flagMatched), .clearFlags(clearFlags), .rdPos(rdPos),
        .rdCard(rdCard), .rdFaceUp(rdFaceUp), .rdMatched(rdMatched));

    cardPlacer #(
        .ORIGIN_X(ORIGIN_X), .ORIGIN_Y(ORIGIN_Y), .PITCH_X(PITCH_X), .PITCH_Y(PITCH_Y)
    ) u_cardPlacer (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN), .rdPos(rdPos), .posX(posX), .posY(posY));

    gameControl u_gameControl (
        .FPGA_Clk(FPGA_Clk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .dealBusy(dealBusy), .dealDone(dealDone),
        .rdCard(rdCard), .rdFaceUp(rdFaceUp), .rdMatched(rdMatched),
        .posX(posX), .posY(posY),
        .dealStart(dealStart), .flagWrEn(flagWrEn), .flagWrSlot(flagWrSlot),
        .flagFaceUp(flagFaceUp), .flagMatched(flagMatched), .clearFlags(clearFlags),
        .rdPos(rdPos));

endmodule

`default_nettype wire

//--- src/gameControl.sv
`default_nettype none

module gameControl
    import memGamePkg::*;
(
    input  wire               FPGA_Clk,
    input  wire               rstN,
    input  wire               wbCyc,
    input  wire               wbStb,
    input  wire               wbWe,
    input  wire  [5:0]        wbAdr,
    input  wire  [31:0]       wbDatW,
    output logic [31:0]       wbDatR,
    output logic              wbAck,
    input  wire               dealBusy,
    input  wire               dealDone,
    input  wire  [SLOT_W-1:0] rdCard,
    input  wire               rdFaceUp,
    input  wire               rdMatched,
    input  wire  [9:0]        posX,
    input  wire  [9:0]        posY,
    output logic              dealStart,
    output logic              flagWrEn,
    output logic [SLOT_W-1:0] flagWrSlot,
    output logic              flagFaceUp,
    output logic              flagMatched,
    output logic              clearFlags,
    output boardPos_u         rdPos
);

    typedef enum logic [2:0] {stIdle, stEval, stDownB, stApply, stMatch} flipState_t;

    flipState_t        state;
    logic [5:0]        ackAdr;
    logic [SLOT_W-1:0] flipSlot, flipCard, firstSlot, firstCard, misA, misB;
    logic              firstOpen, misShow, busReq, accept, doApply, isMatch, gameWon;
    logic [SLOT_W-1:0] curCard;
    logic [3:0]        pairsFound;
    logic [7:0]        attempts;

    // New access only when idle, so a running flip stretches the ack
    assign busReq  = wbCyc && wbStb && !wbAck && (state == stIdle);
    assign gameWon = (pairsFound == 4'(NUM_PAIRS));
    // Table data for the flipped slot is live only in stEval
    assign curCard = (state == stEval) ? rdCard : flipCard;
    assign accept  = dealDone && !rdFaceUp && !rdMatched;
    assign doApply = ((state == stEval) && accept && !misShow) || (state == stApply);
    // Cards 2k and 2k+1 share a pair
    assign isMatch = firstOpen && (curCard[SLOT_W-1:1] == firstCard[SLOT_W-1:1]);

    always_comb
    begin
        // A FLIP looks up its own slot instead of the address
        rdPos.index = wbAdr[SLOT_W-1:0];
        if (wbWe && (wbAdr == ADR_FLIP))
            rdPos.index = wbDatW[SLOT_W-1:0];
    end

    ////////////////////
    // Flag write port
    ////////////////////
    always_comb
    begin
        flagWrEn    = 1'b0;
        flagWrSlot  = flipSlot;
        flagFaceUp  = 1'b1;
        flagMatched = 1'b0;
        if ((state == stEval) && accept && misShow)
        begin
            flagWrEn   = 1'b1;
            flagWrSlot = misA;
            flagFaceUp = 1'b0;
        end
        if (state == stDownB)
        begin
            flagWrEn   = 1'b1;
            flagWrSlot = misB;
            flagFaceUp = 1'b0;
        end
        if (doApply)
        begin
            flagWrEn    = 1'b1;
            flagMatched = isMatch;
        end
        if (state == stMatch)
        begin
            flagWrEn    = 1'b1;
            flagWrSlot  = firstSlot;
            flagMatched = 1'b1;
        end
    end

    ////////////////////
    // Bus and flip sequence
    ////////////////////
    always_ff @(posedge FPGA_Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state      <= stIdle;
            wbAck      <= 1'b0;
            ackAdr     <= '0;
            dealStart  <= 1'b0;
            clearFlags <= 1'b0;
            flipSlot   <= '0;
            flipCard   <= '0;
            firstOpen  <= 1'b0;
            firstSlot  <= '0;
            firstCard  <= '0;
            misShow    <= 1'b0;
            misA       <= '0;
            misB       <= '0;
            pairsFound <= '0;
            attempts   <= '0;
        end
        else
        begin
            wbAck      <= busReq;
            dealStart  <= 1'b0;
            clearFlags <= 1'b0;
            if (busReq)
            begin
                ackAdr <= wbAdr;
                if (wbWe && (wbAdr == ADR_CTRL) && wbDatW[0] && !dealBusy)
                begin
                    dealStart  <= 1'b1;
                    clearFlags <= 1'b1;
                    pairsFound <= '0;
                    attempts   <= '0;
                    firstOpen  <= 1'b0;
                    misShow    <= 1'b0;
                end
                if (wbWe && (wbAdr == ADR_FLIP))
                begin
                    state    <= stEval;
                    flipSlot <= wbDatW[SLOT_W-1:0];
                end
            end
            case (state)
                stEval:
                begin
                    flipCard <= rdCard;
                    if (!accept)
                        state <= stIdle;
                    else if (misShow)
                    begin
                        // First half of turning the old mismatch down
                        misShow <= 1'b0;
                        state   <= stDownB;
                    end
                end
                stDownB: state <= stApply;
                stApply, stMatch: state <= stIdle;
                default: ;
            endcase
            if (doApply)
            begin
                state <= isMatch ? stMatch : stIdle;
                if (!firstOpen)
                begin
                    firstOpen <= 1'b1;
                    firstSlot <= flipSlot;
                    firstCard <= curCard;
                end
                else
                begin
                    firstOpen <= 1'b0;
                    if (attempts != 8'hFF)
                        attempts <= attempts + 1'b1;
                    if (isMatch)
                        pairsFound <= pairsFound + 1'b1;
                    else
                    begin
                        misShow <= 1'b1;
                        misA    <= firstSlot;
                        misB    <= flipSlot;
                    end
                end
            end
        end
    end

    // Read data for the access being acked
    always_comb
    begin
        wbDatR = '0;
        if (ackAdr == ADR_CTRL)
            wbDatR[2:0] = {gameWon, dealDone, dealBusy};
        else if (ackAdr == ADR_SCORE)
        begin
            wbDatR[3:0]  = pairsFound;
            wbDatR[15:8] = attempts;
        end
        else if (ackAdr[5:4] == ADR_SLOT_BASE[5:4])
            wbDatR[5:0] = {rdMatched, rdFaceUp, rdCard};
        else if (ackAdr[5:4] == ADR_POS_BASE[5:4])
        begin
            wbDatR[9:0]   = posX;
            wbDatR[25:16] = posY;
        end
    end

    // Master must hold the strobe through the ack
    ackInCycle: assert property (@(posedge FPGA_Clk) disable iff (!rstN)
        wbAck |-> (wbCyc && wbStb));

endmodule

`default_nettype wire

//--- src/cardPlacer.sv
`default_nettype none

module cardPlacer
    import memGamePkg::*;
#(
    parameter logic [9:0] ORIGIN_X = 10'd64,
    parameter logic [9:0] ORIGIN_Y = 10'd48,
    parameter logic [9:0] PITCH_X  = 10'd128,
    parameter logic [9:0] PITCH_Y  = 10'd104
)
(
    input  wire             FPGA_Clk,
    input  wire             rstN,
    input  wire  boardPos_u rdPos,
    output logic [9:0]      posX,
    output logic [9:0]      posY
);

    // k * pitch for k in 0..3, built from one add
    function automatic logic [9:0] pitchTimes(input logic [1:0] k, input logic [9:0] pitch);
        logic [9:0] acc;
        acc = k[0] ? pitch : 10'd0;
        if (k[1])
        begin
            acc = acc + (pitch << 1);
        end
        return acc;
    endfunction

    logic [9:0] nextX;
    logic [9:0] nextY;

    // Column steps across, row steps down
    assign nextX = ORIGIN_X + pitchTimes(rdPos.grid.col, PITCH_X);
    assign nextY = ORIGIN_Y + pitchTimes(rdPos.grid.row, PITCH_Y);

    always_ff @(posedge FPGA_Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            posX <= '0;
            posY <= '0;
        end
        else
        begin
            posX <= nextX;
            posY <= nextY;
        end
    end

endmodule

`default_nettype wire

//--- src/boardTable.sv
`default_nettype none

module boardTable
    import memGamePkg::*;
(
    input  wire               FPGA_Clk,
    input  wire               rstN,
    input  wire               dealWrEn,
    input  wire  [SLOT_W-1:0] dealWrSlot,
    input  wire  [SLOT_W-1:0] dealWrCard,
    input  wire               flagWrEn,
    input  wire  [SLOT_W-1:0] flagWrSlot,
    input  wire               flagFaceUp,
    input  wire               flagMatched,
    input  wire               clearFlags,
    input  wire  boardPos_u   rdPos,
    output logic [SLOT_W-1:0] rdCard,
    output logic              rdFaceUp,
    output logic              rdMatched
);

    logic [NUM_SLOTS-1:0][SLOT_W-1:0] cards;
    logic [NUM_SLOTS-1:0]             faceUp;
    logic [NUM_SLOTS-1:0]             matched;

    always_ff @(posedge FPGA_Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            cards   <= '0;
            faceUp  <= '0;
            matched <= '0;
        end
        else
        begin
            if (clearFlags)
            begin
                faceUp  <= '0;
                matched <= '0;
            end
            // Newly dealt card starts face down
            if (dealWrEn)
            begin
                cards[dealWrSlot]   <= dealWrCard;
                faceUp[dealWrSlot]  <= 1'b0;
                matched[dealWrSlot] <= 1'b0;
            end
            if (flagWrEn)
            begin
                faceUp[flagWrSlot]  <= flagFaceUp;
                matched[flagWrSlot] <= flagMatched;
            end
        end
    end

    // Registered read, valid one cycle after rdPos
    always_ff @(posedge FPGA_Clk)
    begin
        rdCard    <= cards[rdPos.index];
        rdFaceUp  <= faceUp[rdPos.index];
        rdMatched <= matched[rdPos.index];
    end

    // A found pair stays up for the rest of the game
    matchedStays: assert property (@(posedge FPGA_Clk) disable iff (!rstN)
        (flagWrEn && matched[flagWrSlot]) |-> (flagFaceUp && flagMatched));

endmodule

`default_nettype wire

//--- src/dealShuffler.sv
`default_nettype none

module dealShuffler
    import memGamePkg::*;
(
    input  wire               FPGA_Clk,
    input  wire               rstN,
    input  wire               dealStart,
    input  wire  [SLOT_W-1:0] rndBits,
    output logic              dealWrEn,
    output logic [SLOT_W-1:0] dealWrSlot,
    output logic [SLOT_W-1:0] dealWrCard,
    output logic              dealBusy,
    output logic              dealDone
);

    // One bit per card value already placed
    logic [NUM_SLOTS-1:0] usedMap;
    // Next slot to fill
    logic [SLOT_W-1:0]    fillCnt;
    logic                 drawFree;
    logic                 lastSlot;
    logic [NUM_SLOTS-1:0] cardBit;

    ////////////////////
    // Draw test
    ////////////////////
    // A draw is taken only while dealing and only if that card is still free
    assign drawFree = dealBusy && !usedMap[rndBits];
    assign lastSlot = (fillCnt == SLOT_W'(NUM_SLOTS - 1));

    always_ff @(posedge FPGA_Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            usedMap  <= '0;
            fillCnt  <= '0;
            dealBusy <= 1'b0;
            dealDone <= 1'b0;
            dealWrEn <= 1'b0;
        end
        else
        begin
            dealWrEn <= drawFree;
            if (dealStart && !dealBusy)
            begin
                // Fresh deal, forget every placed card
                usedMap  <= '0;
                fillCnt  <= '0;
                dealBusy <= 1'b1;
                dealDone <= 1'b0;
            end
            else if (drawFree)
            begin
                usedMap[rndBits] <= 1'b1;
                fillCnt          <= fillCnt + 1'b1;
                if (lastSlot)
                begin
                    dealBusy <= 1'b0;
                    dealDone <= 1'b1;
                end
            end
            // Rejected draws just fall through, next cycle brings a new one
        end
    end

    ////////////////////
    // Table write port
    ////////////////////
    always_ff @(posedge FPGA_Clk)
    begin
        if (drawFree)
        begin
            dealWrSlot <= fillCnt;
            dealWrCard <= rndBits;
        end
    end

    // Written card must have been free the cycle it was drawn, and now be marked
    assign cardBit = NUM_SLOTS'(1) << dealWrCard;

    dealNoDup: assert property (@(posedge FPGA_Clk) disable iff (!rstN)
        dealWrEn |-> ((($past(usedMap) & cardBit) == '0) && ((usedMap & cardBit) != '0)));

endmodule

`default_nettype wire

//--- src/lfsrSource.sv
`default_nettype none

module lfsrSource
    import memGamePkg::*;
#(
    parameter logic [15:0] LFSR_SEED = 16'hACE1
)
(
    input  wire               FPGA_Clk,
    input  wire               rstN,
    output logic [SLOT_W-1:0] rndBits
);

    // Taps 16,14,13,11 give a maximal-length sequence
    localparam logic [15:0] TAP_MASK = 16'hB400;

    logic [15:0] lfsrState;

    always_ff @(posedge FPGA_Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            lfsrState <= LFSR_SEED;
        end
        else
        begin
            // Galois form, shift right and fold the output bit back in
            lfsrState <= {1'b0, lfsrState[15:1]} ^ (lfsrState[0] ? TAP_MASK : 16'h0000);
        end
    end

    // Low bits become the card draw
    assign rndBits = lfsrState[SLOT_W-1:0];

    // All-zero state would lock the shuffler forever
    lfsrNonZero: assert property (@(posedge FPGA_Clk) disable iff (!rstN)
        lfsrState != '0);

endmodule

`default_nettype wire

//--- src/memGamePkg.sv
`default_nettype none

package memGamePkg;

    ////////////////////
    // Board geometry
    ////////////////////
    localparam int NUM_SLOTS = 16;
    localparam int SLOT_W    = 4;
    localparam int NUM_PAIRS = 8;

    ////////////////////
    // Register map
    ////////////////////
    // Word addresses on the 6-bit bus address
    localparam logic [5:0] ADR_CTRL      = 6'd0;
    localparam logic [5:0] ADR_FLIP      = 6'd1;
    localparam logic [5:0] ADR_SCORE     = 6'd2;
    // Slot contents, 16 to 31
    localparam logic [5:0] ADR_SLOT_BASE = 6'd16;
    // Card positions, 32 to 47
    localparam logic [5:0] ADR_POS_BASE  = 6'd32;

    // Slot word, linear index or row/column on the 4x4 grid
    typedef union packed {
        logic [SLOT_W-1:0] index;
        struct packed {
            logic [1:0] row;
            logic [1:0] col;
        } grid;
    } boardPos_u;

endpackage

`default_nettype wire
